// File: hdl/alloc_top.sv
`timescale 1ns/1ps

// Request allocator
// Grants up to two of eight requesters per cycle in fixed priority order
// A granted requester stays busy until a release strobe names it
module alloc_top (
  input  logic                  clk,
  input  logic                  rst,
  input  req_pkg::req_vec_t     req,
  input  logic                  rel_vld,
  input  req_pkg::req_idx_t     rel_idx,
  output grant_pkg::grant_vld_t grant_vld,
  output req_pkg::req_idx_t     grant_idx0,
  output req_pkg::req_idx_t     grant_idx1,
  output req_pkg::req_vec_t     busy
);

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------

  // Requests that are neither busy nor granted in the current cycle
  req_pkg::req_vec_t eligible;
  // Onehot winners of the encoder, one vector per grant slot
  req_pkg::req_vec_t [grant_pkg::NUM_GRANT-1:0] winners;
  // Registered union of both grant slots
  req_pkg::req_vec_t granted;

  // Busy flags and request masking
  busy_tracker u_busy_tracker (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .new_busy (granted),
    .pending  (granted),
    .rel_vld  (rel_vld),
    .rel_idx  (rel_idx),
    .eligible (eligible),
    .busy     (busy)
  );

  // Picks the two strongest eligible requesters in the same cycle
  priority_encoder #(
    .num_requesters       (req_pkg::NUM_REQ),
    .num_results          (grant_pkg::NUM_GRANT),
    .msb_highest_priority (grant_pkg::PRIORITY_MSB_FIRST)
  ) u_priority_encoder (
    .in  (eligible),
    .out (winners)
  );

  // Registers the winners and drives the grant strobes
  grant_issue u_grant_issue (
    .clk        (clk),
    .rst        (rst),
    .onehot0    (winners[0]),
    .onehot1    (winners[1]),
    .granted    (granted),
    .grant_vld  (grant_vld),
    .grant_idx0 (grant_idx0),
    .grant_idx1 (grant_idx1)
  );

endmodule

// File: hdl/busy_tracker.sv
`timescale 1ns/1ps

// Keeps one busy flag per requester and masks requests that may not be granted
// A flag is set by the registered grant union and cleared by a release strobe
module busy_tracker (
  input  logic              clk,
  input  logic              rst,
  input  req_pkg::req_vec_t req,
  input  req_pkg::req_vec_t new_busy,
  input  req_pkg::req_vec_t pending,
  input  logic              rel_vld,
  input  req_pkg::req_idx_t rel_idx,
  output req_pkg::req_vec_t eligible,
  output req_pkg::req_vec_t busy
);

  // Registered busy flags
  req_pkg::req_vec_t busy_q;
  // Onehot form of the release strobe, zero when no release is present
  req_pkg::req_vec_t rel_dec;

  // ----------------------------------------------------------------------
  // Release decode
  // ----------------------------------------------------------------------

  always_comb begin
    rel_dec = '0;
    if (rel_vld) begin
      rel_dec[rel_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Busy flags
  // ----------------------------------------------------------------------

  // The release only acts on flags that are already set, so a release of
  // an idle requester leaves it idle, and a grant still in flight wins
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~rel_dec) | new_busy;
    end
  end

  // A grant shown this cycle has not reached busy_q yet
  // Masking pending as well closes that one cycle gap
  assign eligible = req & ~busy_q & ~pending;

  assign busy = busy_q;

endmodule

// File: hdl/grant_issue.sv
`timescale 1ns/1ps

// Registers the onehot grant vectors from the encoder
// Each slot is presented as a valid strobe and a binary requester number
module grant_issue (
  input  logic                  clk,
  input  logic                  rst,
  input  req_pkg::req_vec_t     onehot0,
  input  req_pkg::req_vec_t     onehot1,
  output req_pkg::req_vec_t     granted,
  output grant_pkg::grant_vld_t grant_vld,
  output req_pkg::req_idx_t     grant_idx0,
  output req_pkg::req_idx_t     grant_idx1
);

  // Registered onehot grants, zero in any cycle without a grant
  req_pkg::req_vec_t onehot0_q;
  req_pkg::req_vec_t onehot1_q;

  // Turns a onehot vector into the number of its set bit
  // An all zero vector gives zero, which the valid bit qualifies
  function automatic req_pkg::req_idx_t onehot_to_idx(input req_pkg::req_vec_t vec);
    req_pkg::req_idx_t idx;
    idx = '0;
    for (int i = 0; i < req_pkg::NUM_REQ; i++) begin
      if (vec[i]) begin
        idx = idx | req_pkg::req_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // ----------------------------------------------------------------------
  // Grant registers
  // ----------------------------------------------------------------------

  // Winners of the encoder are captured at every edge and shown for one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      onehot0_q <= '0;
      onehot1_q <= '0;
    end else begin
      onehot0_q <= onehot0;
      onehot1_q <= onehot1;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------

  // Slot 1 is only ever filled when slot 0 is filled as well
  assign grant_vld = {|onehot1_q, |onehot0_q};

  assign grant_idx0 = onehot_to_idx(onehot0_q);
  assign grant_idx1 = onehot_to_idx(onehot1_q);

  // Union of both slots, fed back as pending mask and as busy set
  assign granted = onehot0_q | onehot1_q;

endmodule

// File: hdl/grant_pkg.sv
package grant_pkg;

  // ----------------------------------------------------------------------
  // Grant side of the allocator
  // ----------------------------------------------------------------------

  // Number of grant slots filled in a single cycle
  localparam int NUM_GRANT = 2;

  // Priority direction of the encoder
  // With 0 the requester at index 0 wins over all others
  // With 1 the highest index wins instead
  localparam bit PRIORITY_MSB_FIRST = 1'b0;

  // One valid strobe per grant slot
  // Bit 0 belongs to slot 0, which always takes the stronger requester
  typedef logic [NUM_GRANT-1:0] grant_vld_t;

endpackage

// File: hdl/priority_encoder.sv
`timescale 1ns/1ps

// Multi-result priority encoder
// Result 0 holds the strongest active input bit, result 1 the next one and so on
// Every result is onehot or all zero and no two results share a bit
module priority_encoder #(
  // Number of input bits, kept equal to the requester count of the design
  parameter int num_requesters = req_pkg::NUM_REQ,
  // Number of onehot results produced per evaluation
  parameter int num_results = 1,
  // When set the highest index is the strongest input
  parameter bit msb_highest_priority = 1'b0
) (
  input  req_pkg::req_vec_t                   in,
  output req_pkg::req_vec_t [num_results-1:0] out
);

  // Internal view of the vectors in which bit 0 is always the strongest
  logic [num_requesters-1:0] in_int;
  logic [num_requesters-1:0] out_int [num_results];

  // Running union of the bits already claimed by earlier results
  logic [num_requesters-1:0] taken;
  // Input left over for the result under evaluation
  logic [num_requesters-1:0] masked;

  // ----------------------------------------------------------------------
  // Input orientation
  // ----------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < num_requesters; i++) begin
      if (msb_highest_priority) begin
        // Mirror the vector so the old top bit lands on bit 0
        in_int[i] = in[num_requesters-1-i];
      end else begin
        in_int[i] = in[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Search, one pass per result
  // ----------------------------------------------------------------------

  always_comb begin
    taken = '0;
    masked = '0;
    for (int r = 0; r < num_results; r++) begin
      // Drop every bit that a stronger result already owns
      masked = in_int & ~taken;
      // Adding one to the inverted vector carries up to the lowest set bit
      // and the AND then keeps only that bit
      out_int[r] = masked & (~masked + num_requesters'(1));
      taken = taken | out_int[r];
    end
  end

  // ----------------------------------------------------------------------
  // Output orientation
  // ----------------------------------------------------------------------

  always_comb begin
    for (int r = 0; r < num_results; r++) begin
      for (int j = 0; j < num_requesters; j++) begin
        if (msb_highest_priority) begin
          // Undo the mirroring applied on the input side
          out[r][j] = out_int[r][num_requesters-1-j];
        end else begin
          out[r][j] = out_int[r][j];
        end
      end
    end
  end

endmodule

// File: hdl/req_pkg.sv
package req_pkg;

  // ----------------------------------------------------------------------
  // Requester side of the allocator
  // ----------------------------------------------------------------------

  // Number of requesters that compete for grants
  localparam int NUM_REQ = 8;

  // Width of a binary requester number
  localparam int REQ_IDX_W = $clog2(NUM_REQ);

  // One bit per requester
  // Carries request levels, eligible requests, busy flags and onehot grants
  typedef logic [NUM_REQ-1:0] req_vec_t;

  // Binary requester number as seen on grant and release ports
  typedef logic [REQ_IDX_W-1:0] req_idx_t;

endpackage

// File: run.sh
#!/bin/sh
# Builds the allocator testbench with Verilator and runs it.
# The simulator exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module alloc_tb \
  --Mdir obj_dir \
  -o alloc_sim \
  -f tb.f

./obj_dir/alloc_sim

// File: tb.f
hdl/req_pkg.sv
hdl/grant_pkg.sv
hdl/priority_encoder.sv
hdl/busy_tracker.sv
hdl/grant_issue.sv
hdl/alloc_top.sv
tests/clk_gen.sv
tests/alloc_tb.sv

// File: tests/alloc_tb.sv
`timescale 1ns/1ps

// Directed and random tests for the request allocator
// Inputs change on the falling edge, outputs are sampled on the next falling edge
module alloc_tb;

  localparam int RESET_CYCLES = 5;
  localparam int GRANT_TIMEOUT = 16;
  localparam int RANDOM_CYCLES = 200;
  localparam logic [15:0] LFSR_SEED = 16'd23236;

  logic                  clk;
  logic                  rst;
  req_pkg::req_vec_t     req;
  logic                  rel_vld;
  req_pkg::req_idx_t     rel_idx;
  grant_pkg::grant_vld_t grant_vld;
  req_pkg::req_idx_t     grant_idx0;
  req_pkg::req_idx_t     grant_idx1;
  req_pkg::req_vec_t     busy;

  // Reference model state, updated once per rising edge
  req_pkg::req_vec_t     m_busy;
  req_pkg::req_vec_t     m_granted;
  grant_pkg::grant_vld_t m_vld;
  req_pkg::req_idx_t     m_idx0;
  req_pkg::req_idx_t     m_idx1;

  logic [15:0] lfsr_state;

  clk_gen #(.period_ns(8)) u_clk_gen (.clk(clk));

  alloc_top uut (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .rel_vld    (rel_vld),
    .rel_idx    (rel_idx),
    .grant_vld  (grant_vld),
    .grant_idx0 (grant_idx0),
    .grant_idx1 (grant_idx1),
    .busy       (busy)
  );

  // ----------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ----------------------------------------------------------------------

  task automatic stop_on_failure(input string why);
    $display("Regression failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_vld(input grant_pkg::grant_vld_t got,
                           input grant_pkg::grant_vld_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
      stop_on_failure("grant valid mismatch");
    end
  endtask

  task automatic check_idx(input req_pkg::req_idx_t got,
                           input req_pkg::req_idx_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s, got %0d expected %0d", $time, what, got, exp);
      stop_on_failure("grant index mismatch");
    end
  endtask

  task automatic check_busy(input req_pkg::req_vec_t got,
                            input req_pkg::req_vec_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
      stop_on_failure("busy vector mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // Random source
  // ----------------------------------------------------------------------

  // Galois form, taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  // Shifts in one LFSR output bit per step, up to eight bits
  task automatic take_bits(input int n, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Eligible means requesting, not busy and not granted in the current cycle
  // The lowest eligible index fills slot 0 and the next one fills slot 1
  task automatic model_step();
    req_pkg::req_vec_t     elig;
    req_pkg::req_vec_t     next_granted;
    req_pkg::req_vec_t     next_busy;
    grant_pkg::grant_vld_t next_vld;
    req_pkg::req_idx_t     next_idx0;
    req_pkg::req_idx_t     next_idx1;
    int                    found;
    elig = req & ~m_busy & ~m_granted;
    next_granted = '0;
    next_vld = '0;
    next_idx0 = '0;
    next_idx1 = '0;
    found = 0;
    for (int i = 0; i < req_pkg::NUM_REQ; i++) begin
      if (elig[i] && found < grant_pkg::NUM_GRANT) begin
        if (found == 0) begin
          next_vld[0] = 1'b1;
          next_idx0 = req_pkg::req_idx_t'(i);
        end else begin
          next_vld[1] = 1'b1;
          next_idx1 = req_pkg::req_idx_t'(i);
        end
        next_granted[i] = 1'b1;
        found++;
      end
    end
    // A release only clears a flag that is set, grants shown now become busy
    next_busy = m_busy;
    if (rel_vld && m_busy[rel_idx]) begin
      next_busy[rel_idx] = 1'b0;
    end
    next_busy = next_busy | m_granted;
    m_busy = next_busy;
    m_granted = next_granted;
    m_vld = next_vld;
    m_idx0 = next_idx0;
    m_idx1 = next_idx1;
  endtask

  task automatic compare_model();
    check_vld(grant_vld, m_vld, "grant valid against model");
    if (m_vld[0]) begin
      check_idx(grant_idx0, m_idx0, "slot 0 index against model");
    end
    if (m_vld[1]) begin
      check_idx(grant_idx1, m_idx1, "slot 1 index against model");
    end
    check_busy(busy, m_busy, "busy against model");
  endtask

  // One clock cycle, called and returning on a falling edge
  task automatic tick();
    model_step();
    @(posedge clk);
    @(negedge clk);
    compare_model();
  endtask

  // The model already expects the grant on the first edge
  task automatic wait_grant();
    int cycles;
    cycles = 1;
    tick();
    while (grant_vld[0] !== 1'b1) begin
      if (cycles >= GRANT_TIMEOUT) begin
        $display("No grant arrived within %0d cycles", GRANT_TIMEOUT);
        stop_on_failure("timeout while waiting for a grant");
      end
      tick();
      cycles++;
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
    end
    @(negedge clk);
    rst = 1'b0;
    m_busy = '0;
    m_granted = '0;
    m_vld = '0;
    m_idx0 = '0;
    m_idx1 = '0;
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------

  task automatic test_single_request();
    check_vld(grant_vld, 2'b00, "grant valid after reset");
    check_busy(busy, 8'h00, "busy after reset");
    req = 8'h20;
    wait_grant();
    check_vld(grant_vld, 2'b01, "single request valid");
    check_idx(grant_idx0, 3'd5, "single request slot 0");
    tick();
    check_busy(busy, 8'h20, "busy one cycle after grant");
    check_vld(grant_vld, 2'b00, "no second grant for index 5");
    // Drop the request and free index 5 again
    req = 8'h00;
    rel_vld = 1'b1;
    rel_idx = 3'd5;
    tick();
    rel_vld = 1'b0;
    check_busy(busy, 8'h00, "busy after releasing index 5");
  endtask

  task automatic test_two_slots();
    req = 8'h54;
    wait_grant();
    check_vld(grant_vld, 2'b11, "both slots valid");
    check_idx(grant_idx0, 3'd2, "slot 0 takes index 2");
    check_idx(grant_idx1, 3'd4, "slot 1 takes index 4");
    tick();
    check_vld(grant_vld, 2'b01, "leftover request granted");
    check_idx(grant_idx0, 3'd6, "slot 0 takes index 6");
    check_busy(busy, 8'h14, "indices 2 and 4 busy");
    tick();
    check_vld(grant_vld, 2'b00, "nothing left to grant");
    check_busy(busy, 8'h54, "indices 2, 4 and 6 busy");
  endtask

  task automatic test_busy_hold();
    // Requests on 2, 4 and 6 are still held from the previous test
    for (int i = 0; i < 5; i++) begin
      tick();
      check_vld(grant_vld, 2'b00, "busy requester granted again");
      check_busy(busy, 8'h54, "busy while holding requests");
    end
  endtask

  task automatic test_release();
    rel_vld = 1'b1;
    rel_idx = 3'd4;
    tick();
    rel_vld = 1'b0;
    check_busy(busy, 8'h44, "index 4 released");
    check_vld(grant_vld, 2'b00, "no grant on the release edge");
    tick();
    check_vld(grant_vld, 2'b01, "regrant after release");
    check_idx(grant_idx0, 3'd4, "index 4 regranted");
    tick();
    check_busy(busy, 8'h54, "index 4 busy again");
    // Index 1 neither requests nor is busy
    rel_vld = 1'b1;
    rel_idx = 3'd1;
    tick();
    rel_vld = 1'b0;
    check_busy(busy, 8'h54, "release of idle requester");
    check_vld(grant_vld, 2'b00, "no grant after idle release");
    req = 8'h00;
    for (int i = 2; i <= 6; i += 2) begin
      rel_vld = 1'b1;
      rel_idx = req_pkg::req_idx_t'(i);
      tick();
    end
    rel_vld = 1'b0;
    check_busy(busy, 8'h00, "all released");
  endtask

  task automatic test_random();
    logic [7:0] bits;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      take_bits(8, bits);
      req = bits;
      take_bits(1, bits);
      rel_vld = bits[0];
      take_bits(3, bits);
      rel_idx = bits[2:0];
      tick();
    end
    req = 8'h00;
    rel_vld = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst = 1'b1;
    req = '0;
    rel_vld = 1'b0;
    rel_idx = '0;
    lfsr_state = LFSR_SEED;
    apply_reset();
    test_single_request();
    test_two_slots();
    test_busy_hold();
    test_release();
    test_random();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/1ps

// Free running clock for the testbench
// The first rising edge comes half a period after time zero
module clk_gen #(
  parameter int period_ns = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2);
      clk = ~clk;
    end
  end

endmodule
